/* hdl/fetch_cfg.svh */
// Build constants for the RV32I fetch front end.
// Queue depths are entry counts and need not be powers of two.
// XLEN is fixed at 32 because the decode stage only knows RV32I.
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address after reset
`define PC_START 32'h8000_0000

`define XLEN 32

// fetch to decode buffer
`define IQ_DEPTH 2
// decode output buffer
`define OQ_DEPTH 4
`endif

/* hdl/mem_bus_pkg.sv */
// Instruction memory port types.
// Only word accesses are issued, and any nonzero resp counts as an error.
`default_nettype none
`include "fetch_cfg.svh"

package mem_bus_pkg;

  localparam logic [1:0] SIZE_WORD = 2'd2;
  localparam logic [1:0] RESP_OKAY = 2'd0;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [1:0]       size;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic [1:0]       resp;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
// Payload types passed between the front end stages.
// FAULT marks unknown opcodes and words fetched with an error response.
`default_nettype none
`include "fetch_cfg.svh"

package pipe_pkg;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
    logic             fault;
  } fetch_pkt_t;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH,
    CLS_JAL, CLS_JALR, CLS_SYSTEM, CLS_FAULT
  } inst_class_e;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
    inst_class_e      cls;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
  } decoded_t;

  // one-cycle strobe from decode back to fetch
  typedef struct packed {
    logic             valid;
    logic             taken;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* hdl/if_stage.sv */
// Fetch stage with a single outstanding word request.
// After reset the first request goes to PC_START. Every later fetch waits
// in IDLE for a redirect strobe from decode.
// The response is sampled exactly one cycle after the address handshake
// and is held until the packet is taken by the queue.
// mem_req stays stable while mem_req_valid is high.
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module if_stage
  import mem_bus_pkg::*, pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // instruction memory
  output logic       mem_req_valid,
  output mem_req_t   mem_req,
  input  logic       mem_req_ready,
  input  mem_rsp_t   mem_rsp,

  // to the instruction queue
  output logic       pkt_valid,
  output fetch_pkt_t pkt,
  input  logic       pkt_ready,

  // from decode
  input  redirect_t  redirect
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RETN
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] next_pc;
  logic             req_valid_q;
  logic             rsp_pending_q;
  mem_rsp_t         rsp_q;
  logic             req_fire;
  logic             pkt_fire;

  assign req_fire = req_valid_q && mem_req_ready;

  // packet is offered once the response word has been captured
  assign pkt_valid = (state_q == RETN) && !rsp_pending_q;
  assign pkt_fire  = pkt_valid && pkt_ready;

  assign next_pc = redirect.taken ? redirect.target : addr_q + `XLEN'd4;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (redirect.valid) begin
          state_d = ADDR;
        end
      end
      ADDR: begin
        if (req_fire) begin
          state_d = RETN;
        end
      end
      RETN: begin
        if (pkt_fire) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= ADDR;
      req_valid_q   <= 1'b0;
      rsp_pending_q <= 1'b0;
      addr_q        <= `PC_START;
    end else begin
      state_q       <= state_d;
      // registered so that valid stays low through reset
      req_valid_q   <= (state_d == ADDR);
      rsp_pending_q <= req_fire;
      if (state_q == IDLE && redirect.valid) begin
        addr_q <= next_pc;
      end
    end
  end

  // response word arrives the cycle after the handshake
  always_ff @(posedge clk) begin
    if (rsp_pending_q) begin
      rsp_q <= mem_rsp;
    end
  end

  assign mem_req_valid = req_valid_q;
  assign mem_req.addr  = addr_q;
  assign mem_req.size  = SIZE_WORD;

  assign pkt.pc    = addr_q;
  assign pkt.inst  = rsp_q.data;
  assign pkt.fault = (rsp_q.resp != RESP_OKAY);

endmodule

`default_nettype wire

/* hdl/inst_queue.sv */
// Valid/ready FIFO for any packed payload type.
// A word written in one cycle shows at the output in the next cycle.
// in_ready drops when full. No bypass and no simultaneous write when full,
// so the full depth costs one cycle of latency.
`timescale 1ns/10ps
`default_nettype none

module inst_queue #(
  parameter type data_t = logic [31:0],
  parameter int  DEPTH  = 2
) (
  input  logic  clk,
  input  logic  rst,

  input  logic  in_valid,
  output logic  in_ready,
  input  data_t in_data,

  output logic  out_valid,
  input  logic  out_ready,
  output data_t out_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  data_t         mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
// Combinational RV32I decode with JAL resolution.
// JALR and branches are classified but never taken here, since fetch
// continues at pc+4 for them. Fault packets and unknown opcodes give
// class FAULT with a zero immediate.
// The redirect strobe fires in the same cycle a packet is accepted.
`timescale 1ns/10ps
`default_nettype none

module id_stage
  import pipe_pkg::*;
(
  input  logic       in_valid,
  output logic       in_ready,
  input  fetch_pkt_t in_pkt,

  output logic       out_valid,
  input  logic       out_ready,
  output decoded_t   out,

  output redirect_t  redirect
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  logic [31:0] inst;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm;
  inst_class_e cls;
  logic        accept;

  assign inst = in_pkt.inst;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    cls = CLS_FAULT;
    imm = '0;
    if (!in_pkt.fault) begin
      case (inst[6:0])
        OP_LUI, OP_AUIPC: begin cls = CLS_ALU; imm = imm_u; end
        OP_IMM:           begin cls = CLS_ALU; imm = imm_i; end
        // register-register ops carry no immediate
        OP_REG:           cls = CLS_ALU;
        OP_LOAD:          begin cls = CLS_LOAD; imm = imm_i; end
        OP_STORE:         begin cls = CLS_STORE; imm = imm_s; end
        OP_BRANCH:        begin cls = CLS_BRANCH; imm = imm_b; end
        OP_JAL:           begin cls = CLS_JAL; imm = imm_j; end
        OP_JALR:          begin cls = CLS_JALR; imm = imm_i; end
        OP_FENCE, OP_SYSTEM: begin cls = CLS_SYSTEM; imm = imm_i; end
        default:          cls = CLS_FAULT;
      endcase
    end
  end

  // stall whole stage on output back-pressure
  assign in_ready  = out_ready;
  assign out_valid = in_valid;
  assign accept    = in_valid && out_ready;

  assign out.pc   = in_pkt.pc;
  assign out.inst = inst;
  assign out.cls  = cls;
  assign out.rd   = inst[11:7];
  assign out.rs1  = inst[19:15];
  assign out.rs2  = inst[24:20];
  assign out.imm  = imm;

  assign redirect.valid  = accept;
  assign redirect.taken  = accept && (cls == CLS_JAL);
  assign redirect.target = (cls == CLS_JAL) ? in_pkt.pc + imm : in_pkt.pc + 32'd4;

endmodule

`default_nettype wire

/* hdl/frontend_top.sv */
// RV32I front end: fetch, fetch queue, decode and output queue.
// Only one instruction is in flight between fetch and decode at a time.
// out_ready back-pressure fills the output queue and then stalls decode.
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module frontend_top
  import mem_bus_pkg::*, pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  output logic     mem_req_valid,
  output mem_req_t mem_req,
  input  logic     mem_req_ready,
  input  mem_rsp_t mem_rsp,

  output logic     out_valid,
  input  logic     out_ready,
  output decoded_t out
);

  logic       if_valid;
  logic       if_ready;
  fetch_pkt_t if_pkt;
  logic       iq_valid;
  logic       iq_ready;
  fetch_pkt_t iq_pkt;
  logic       id_valid;
  logic       id_ready;
  decoded_t   id_out;
  redirect_t  redirect;

  if_stage u_if_stage (
    .clk           (clk),
    .rst           (rst),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp),
    .pkt_valid     (if_valid),
    .pkt           (if_pkt),
    .pkt_ready     (if_ready),
    .redirect      (redirect)
  );

  inst_queue #(.data_t(fetch_pkt_t), .DEPTH(`IQ_DEPTH)) u_iq (
    .clk (clk), .rst (rst),
    .in_valid  (if_valid), .in_ready  (if_ready), .in_data  (if_pkt),
    .out_valid (iq_valid), .out_ready (iq_ready), .out_data (iq_pkt)
  );

  id_stage u_id_stage (
    .in_valid  (iq_valid), .in_ready  (iq_ready), .in_pkt (iq_pkt),
    .out_valid (id_valid), .out_ready (id_ready), .out    (id_out),
    .redirect  (redirect)
  );

  inst_queue #(.data_t(decoded_t), .DEPTH(`OQ_DEPTH)) u_oq (
    .clk (clk), .rst (rst),
    .in_valid  (id_valid),  .in_ready  (id_ready),  .in_data  (id_out),
    .out_valid (out_valid), .out_ready (out_ready), .out_data (out)
  );

endmodule

`default_nettype wire

/* bench/frontend_checker.sv */
// Reference model for the front end, fed only from the DUT ports.
// Each output counts as one test and gets one line when it leaves.
// Next fetch address is pc+4, or pc plus the J immediate for a JAL
// that came back without an error response.
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module frontend_checker
  import mem_bus_pkg::*, pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_req_valid,
  input  mem_req_t mem_req,
  input  logic     mem_req_ready,
  input  mem_rsp_t mem_rsp,
  input  logic     out_valid,
  input  logic     out_ready,
  input  decoded_t out,
  output int       out_count,
  output int       pass_count,
  output int       err_count
);

  // completed memory transactions, oldest first
  fetch_pkt_t  txn_q[$];
  logic [31:0] exp_addr;
  logic        rsp_due;
  logic        waiting;
  mem_req_t    held_req;
  logic        rst_q = 1'b1;
  int          req_count;

  function automatic decoded_t model_decode(fetch_pkt_t p);
    decoded_t    d;
    logic [31:0] w;
    w      = p.inst;
    d.pc   = p.pc;
    d.inst = w;
    d.rd   = w[11:7];
    d.rs1  = w[19:15];
    d.rs2  = w[24:20];
    d.cls  = CLS_FAULT;
    if (!p.fault) begin
      case (w[6:0])
        7'h37, 7'h17, 7'h13, 7'h33: d.cls = CLS_ALU;
        7'h03: d.cls = CLS_LOAD;
        7'h23: d.cls = CLS_STORE;
        7'h63: d.cls = CLS_BRANCH;
        7'h6f: d.cls = CLS_JAL;
        7'h67: d.cls = CLS_JALR;
        7'h0f, 7'h73: d.cls = CLS_SYSTEM;
        default: d.cls = CLS_FAULT;
      endcase
    end
    case (d.cls)
      CLS_LOAD, CLS_JALR, CLS_SYSTEM: d.imm = {{21{w[31]}}, w[30:20]};
      CLS_STORE: d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      CLS_BRANCH: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      CLS_JAL: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      // R-type has no immediate and LUI/AUIPC take the U form
      CLS_ALU: d.imm = (w[6:0] == 7'h13) ? {{21{w[31]}}, w[30:20]} :
                       (w[6:0] == 7'h33) ? 32'h0 : {w[31:12], 12'h000};
      default: d.imm = 32'h0;
    endcase
    return d;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR: %s at %0t", msg, $time);
    err_count++;
  endtask

  task automatic compare(input string name, input logic [31:0] exp,
                         input logic [31:0] got, inout logic ok);
    if (got !== exp) begin
      $display("MISMATCH %s expected %h got %h", name, exp, got);
      err_count++;
      ok = 1'b0;
    end
  endtask

  task automatic capture_response();
    fetch_pkt_t t;
    decoded_t   d;
    if (rsp_due) begin
      t.pc    = held_req.addr;
      t.inst  = mem_rsp.data;
      t.fault = (mem_rsp.resp != 2'd0);
      txn_q.push_back(t);
      d        = model_decode(t);
      exp_addr = (d.cls == CLS_JAL) ? t.pc + d.imm : t.pc + 32'd4;
      rsp_due  = 1'b0;
    end
  endtask

  task automatic check_request();
    logic ok;
    ok = 1'b1;
    if (mem_req_valid === 1'b1) begin
      // word accesses only, encoded as 2
      compare("mem_req.size", 32'd2, 32'(mem_req.size), ok);
      if (waiting) begin
        compare("mem_req.addr (held)", held_req.addr, mem_req.addr, ok);
      end
      held_req = mem_req;
      waiting  = !mem_req_ready;
      if (mem_req_ready === 1'b1) begin
        req_count++;
        if (rsp_due) begin
          report_error("new request before the previous response came back");
        end
        compare("mem_req.addr", exp_addr, mem_req.addr, ok);
        if (req_count - out_count > `OQ_DEPTH + 1) begin
          report_error("more memory requests than outputs can account for");
        end
        rsp_due = 1'b1;
      end
    end else if (waiting) begin
      report_error("mem_req_valid dropped before the handshake");
      waiting = 1'b0;
    end
  endtask

  task automatic check_output();
    fetch_pkt_t t;
    decoded_t   e;
    logic       ok;
    ok = 1'b1;
    if (out_valid === 1'b1 && out_ready === 1'b1) begin
      out_count++;
      if (txn_q.size() == 0) begin
        report_error("output appeared with no matching memory transaction");
        ok = 1'b0;
      end else begin
        t = txn_q.pop_front();
        e = model_decode(t);
        compare("out.pc", e.pc, out.pc, ok);
        compare("out.inst", e.inst, out.inst, ok);
        compare("out.cls", 32'(e.cls), 32'(out.cls), ok);
        compare("out.rd", 32'(e.rd), 32'(out.rd), ok);
        compare("out.rs1", 32'(e.rs1), 32'(out.rs1), ok);
        compare("out.rs2", 32'(e.rs2), 32'(out.rs2), ok);
        compare("out.imm", e.imm, out.imm, ok);
      end
      if (ok) begin
        pass_count++;
        $display("test %0d pc %h inst %h ok", out_count, out.pc, out.inst);
      end else begin
        $display("test %0d pc %h inst %h failed", out_count, out.pc, out.inst);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      txn_q.delete();
      exp_addr   = `PC_START;
      rsp_due    = 1'b0;
      waiting    = 1'b0;
      req_count  = 0;
      out_count  = 0;
      pass_count = 0;
      err_count  = 0;
    end else begin
      if (rst_q && (mem_req_valid !== 1'b0 || out_valid !== 1'b0)) begin
        report_error("valid outputs are not low right after reset");
      end
      // response first since it sets the address the next request must use
      capture_response();
      check_request();
      check_output();
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

/* bench/tb_frontend.sv */
// Testbench for the RV32I front end.
// Memory answers each request after 0 to 3 wait cycles with a random word,
// and 5% of responses carry an error code. out_ready is about 70% high.
// All inputs change on the falling clock edge.
`timescale 1ns/10ps
`default_nettype none

module tb_frontend
  import mem_bus_pkg::*, pipe_pkg::*;
();

  localparam int NUM_OUTPUTS       = 400;
  localparam int CYCLES_PER_OUTPUT = 12;
  localparam int RESET_CYCLES      = 4;
  localparam int CLK_PERIOD        = 100;

  logic     clk = 1'b0;
  logic     rst;
  logic     mem_req_valid;
  mem_req_t mem_req;
  logic     mem_req_ready;
  mem_rsp_t mem_rsp;
  logic     out_valid;
  logic     out_ready;
  decoded_t out;
  int       out_count;
  int       pass_count;
  int       err_count;
  logic     mem_busy;
  int       mem_delay;

  always #(CLK_PERIOD / 2) clk = ~clk;

  frontend_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out           (out)
  );

  frontend_checker u_checker (
    .clk (clk), .rst (rst),
    .mem_req_valid (mem_req_valid), .mem_req (mem_req),
    .mem_req_ready (mem_req_ready), .mem_rsp (mem_rsp),
    .out_valid (out_valid), .out_ready (out_ready), .out (out),
    .out_count (out_count), .pass_count (pass_count), .err_count (err_count)
  );

  // mix of ALU/LOAD/STORE, short JALs, branches and raw bits
  function automatic logic [31:0] make_inst();
    int unsigned pick;
    logic [31:0] bits;
    logic [20:0] off;
    logic [6:0]  op;
    pick = $urandom_range(99);
    bits = $urandom();
    if (pick < 60) begin
      case ($urandom_range(5))
        0: op = 7'b0010011;
        1: op = 7'b0110011;
        2: op = 7'b0110111;
        3: op = 7'b0010111;
        4: op = 7'b0000011;
        default: op = 7'b0100011;
      endcase
      return {bits[31:7], op};
    end else if (pick < 75) begin
      // jump within 16 words either way
      off = 21'((int'($urandom_range(32)) - 16) * 4);
      return {off[20], off[10:1], off[11], off[19:12], bits[11:7], 7'b1101111};
    end else if (pick < 85) begin
      return {bits[31:7], 7'b1100011};
    end
    return bits;
  endfunction

  task automatic drive_memory();
    if (mem_req_ready) begin
      // handshake happened on the last rising edge
      mem_req_ready = 1'b0;
      mem_rsp.data  = make_inst();
      mem_rsp.resp  = ($urandom_range(99) < 5) ? 2'($urandom_range(3, 1)) : 2'd0;
      mem_busy      = 1'b0;
    end else begin
      if (!mem_busy && mem_req_valid === 1'b1) begin
        mem_busy  = 1'b1;
        mem_delay = $urandom_range(3);
      end
      if (mem_busy && mem_delay == 0) begin
        mem_req_ready = 1'b1;
      end else if (mem_busy) begin
        mem_delay--;
      end
    end
  endtask

  initial begin : main
    void'($urandom(85253));
    rst           = 1'b1;
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    out_ready     = 1'b0;
    mem_busy      = 1'b0;
    mem_delay     = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (out_count < NUM_OUTPUTS) begin
      @(negedge clk);
      drive_memory();
      out_ready = ($urandom_range(99) < 70);
    end
    $display("outputs %0d, passed %0d, failed %0d, check errors %0d",
             out_count, pass_count, out_count - pass_count, err_count);
    if (err_count == 0 && pass_count == out_count) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + NUM_OUTPUTS * CYCLES_PER_OUTPUT) @(posedge clk);
    $display("timeout: only %0d of %0d outputs arrived in time", out_count, NUM_OUTPUTS);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/pipe_pkg.sv
hdl/if_stage.sv
hdl/inst_queue.sv
hdl/id_stage.sv
hdl/frontend_top.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

/* Bender.yml */
package:
  name: rv32i_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_bus_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/if_stage.sv
      - hdl/inst_queue.sv
      - hdl/id_stage.sv
      - hdl/frontend_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/frontend_checker.sv
      - bench/tb_frontend.sv
